// File: src/sudoku_params.svh
`ifndef SUDOKU_PARAMS_SVH
`define SUDOKU_PARAMS_SVH

// ==================================================
// board geometry
// ==================================================

// cells along one row, column or box line
`define BOARD_SIDE  9

// box edge
`define BOX_SIDE    3

// whole board in row-major order
`define CELL_COUNT  81

// digits 1..9
`define DIGIT_COUNT 9

// selector answer when no empty cell has a candidate
`define NO_CELL     81

`endif

// File: src/sudokuPkg.sv
`default_nettype none

`include "sudoku_params.svh"

package sudokuPkg;

    // ==================================================
    // value types
    // ==================================================

    // one cell digit where 0 means empty
    typedef logic [3:0] cellValue;

    // bit k = digit k+1 (used or candidate)
    typedef logic [`DIGIT_COUNT-1:0] digitMask;

    // row-major position 0..80 or 81 for none
    typedef logic [6:0] cellIndex;

    // number of entries on the search stack
    typedef logic [6:0] stackDepth;

    // 0..9 candidates or 10 as none yet
    typedef logic [3:0] candCount;

    // ==================================================
    // search FSM
    // ==================================================

    typedef enum logic [2:0] {
        Idle,
        Load,
        Select,
        Try,
        Clear,
        Retry,
        Emit
    } searchState;

endpackage

`default_nettype wire

// File: src/candidateIf.sv
`timescale 1ns/10ps
`default_nettype none

interface candidateIf import sudokuPkg::*; ();

    // board status combinational from the current board
    logic     solved;
    logic     contradiction;
    // MRV pick
    cellIndex bestIdx;
    // candidate lookup for the stack top
    cellIndex probeIdx;
    digitMask probeMask;

    modport evalPort (
        output solved,
        output contradiction,
        output probeMask,
        input  probeIdx
    );

    modport selectPort (
        output bestIdx
    );

    modport searchPort (
        input  solved,
        input  contradiction,
        input  bestIdx,
        input  probeMask,
        output probeIdx
    );

endinterface

`default_nettype wire

// File: src/sudokuBoard.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module sudokuBoard import sudokuPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     loadEn,
    input  cellValue loadVal,
    input  logic     updateEn,
    input  cellIndex updateIdx,
    input  cellValue updateVal,
    input  cellIndex readIdx,
    input  logic     emitEn,
    output cellValue cells [`CELL_COUNT],
    output cellValue cellOut,
    output logic     cellOutValid
);

    // ==================================================
    // cell storage
    // ==================================================

    cellValue grid [`CELL_COUNT];

    // load shifts toward index 0 and the newest cell enters at the end
    // so after 81 strobes the first cell sits at index 0
    always_ff @(posedge clk) begin
        if (loadEn) begin
            for (int i = 0; i < `CELL_COUNT - 1; i++) begin
                grid[i] <= grid[i + 1];
            end
            grid[`CELL_COUNT - 1] <= loadVal;
        end else if (updateEn) begin
            // single cell write from search (place or clear)
            grid[updateIdx] <= updateVal;
        end
    end

    assign cells = grid;

    // ==================================================
    // registered read port
    // ==================================================

    // data one cycle after readIdx and zero outside emit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cellOut      <= '0;
            cellOutValid <= 1'b0;
        end else begin
            cellOutValid <= emitEn;
            if (emitEn) begin
                cellOut <= grid[readIdx];
            end else begin
                cellOut <= '0;
            end
        end
    end

    // nothing above 9 ever lands in the board
    assert property (@(posedge clk) disable iff (!rst_n)
        (loadEn |-> loadVal <= `DIGIT_COUNT) and
        (updateEn && !loadEn |-> updateVal <= `DIGIT_COUNT));

endmodule

`default_nettype wire

// File: src/constraintEval.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module constraintEval import sudokuPkg::*; (
    input  cellValue cells [`CELL_COUNT],
    output digitMask candidates [`CELL_COUNT],
    candidateIf.evalPort cand
);

    // one-hot mask for a digit and nothing for an empty cell
    function automatic digitMask digitBit(input cellValue v);
        digitMask m;
        m = '0;
        if (v != 4'd0) begin
            m = digitMask'(1) << (v - 4'd1);
        end
        return m;
    endfunction

    // ==================================================
    // used-digit masks per row / column / box
    // ==================================================

    digitMask rowUsed [`BOARD_SIDE];
    digitMask colUsed [`BOARD_SIDE];
    digitMask boxUsed [`BOARD_SIDE];
    digitMask candMask [`CELL_COUNT];

    always_comb begin
        int boxNum;
        boxNum = 0;
        for (int g = 0; g < `BOARD_SIDE; g++) begin
            rowUsed[g] = '0;
            colUsed[g] = '0;
            boxUsed[g] = '0;
        end
        for (int i = 0; i < `CELL_COUNT; i++) begin
            // band of three rows then stack of three columns
            boxNum = (i / (`BOARD_SIDE * `BOX_SIDE)) * `BOX_SIDE
                   + (i % `BOARD_SIDE) / `BOX_SIDE;
            rowUsed[i / `BOARD_SIDE] |= digitBit(cells[i]);
            colUsed[i % `BOARD_SIDE] |= digitBit(cells[i]);
            boxUsed[boxNum]          |= digitBit(cells[i]);
        end
    end

    // ==================================================
    // candidates and board status
    // ==================================================

    always_comb begin
        int boxNum;
        boxNum = 0;
        cand.solved        = 1'b1;
        cand.contradiction = 1'b0;
        for (int i = 0; i < `CELL_COUNT; i++) begin
            boxNum = (i / (`BOARD_SIDE * `BOX_SIDE)) * `BOX_SIDE
                   + (i % `BOARD_SIDE) / `BOX_SIDE;
            if (cells[i] == 4'd0) begin
                // digits missing from all three groups
                candMask[i] = ~(rowUsed[i / `BOARD_SIDE] | colUsed[i % `BOARD_SIDE]
                              | boxUsed[boxNum]);
                cand.solved = 1'b0;
                // dead end when empty but nothing fits
                if (candMask[i] == '0) begin
                    cand.contradiction = 1'b1;
                end
            end else begin
                candMask[i] = '0;
            end
        end
    end

    assign candidates = candMask;

    // probe for the stack top where out of range reads as no candidates
    assign cand.probeMask = (cand.probeIdx < `CELL_COUNT) ? candMask[cand.probeIdx] : '0;

endmodule

`default_nettype wire

// File: src/cellSelector.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module cellSelector import sudokuPkg::*; (
    input  digitMask candidates [`CELL_COUNT],
    candidateIf.selectPort cand
);

    // plain adder-chain popcount
    function automatic candCount countBits(input digitMask m);
        candCount n;
        n = '0;
        for (int k = 0; k < `DIGIT_COUNT; k++) begin
            n += candCount'(m[k]);
        end
        return n;
    endfunction

    // ==================================================
    // minimum remaining values scan
    // ==================================================

    candCount bestCount;
    cellIndex bestSoFar;

    always_comb begin
        candCount n;
        n = '0;
        // start above any real count
        bestCount = candCount'(`DIGIT_COUNT + 1);
        bestSoFar = cellIndex'(`NO_CELL);
        for (int i = 0; i < `CELL_COUNT; i++) begin
            n = countBits(candidates[i]);
            // strict compare keeps the lowest index on ties
            // filled cells have zero candidates and drop out
            if (n != '0 && n < bestCount) begin
                bestCount = n;
                bestSoFar = cellIndex'(i);
            end
        end
    end

    assign cand.bestIdx = bestSoFar;

endmodule

`default_nettype wire

// File: src/searchControl.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module searchControl import sudokuPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inValid,
    candidateIf.searchPort cand,
    output logic     loadEn,
    output logic     updateEn,
    output cellIndex updateIdx,
    output cellValue updateVal,
    output cellIndex readIdx,
    output logic     emitEn
);

    // one-hot digit mask to cell value
    function automatic cellValue maskToDigit(input digitMask oneHot);
        cellValue v;
        v = '0;
        for (int k = 0; k < `DIGIT_COUNT; k++) begin
            if (oneHot[k]) begin
                v = cellValue'(k + 1);
            end
        end
        return v;
    endfunction

    searchState state;
    searchState nextState;
    stackDepth  depth;
    cellIndex   emitCnt;

    // stack entry = branch cell + digits already tried there
    cellIndex stackIdx   [`CELL_COUNT];
    digitMask stackTried [`CELL_COUNT];

    cellIndex topIdx;
    digitMask topTried;
    digitMask remaining;
    digitMask pickBit;
    logic     pushEn;

    // ==================================================
    // stack top view
    // ==================================================

    assign topIdx   = (depth != '0) ? stackIdx[depth - 1'b1] : '0;
    assign topTried = (depth != '0) ? stackTried[depth - 1'b1] : '0;

    assign cand.probeIdx = topIdx;

    // untried candidates of the top cell where the lowest one wins
    assign remaining = cand.probeMask & ~topTried;
    assign pickBit   = remaining & (~remaining + 1'b1);

    assign pushEn = (state == Select) && !cand.solved && !cand.contradiction;

    // ==================================================
    // next state
    // ==================================================

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (inValid) begin
                    nextState = Load;
                end
            end
            Load: begin
                // first gap in in_valid starts the search
                if (!inValid) begin
                    nextState = Select;
                end
            end
            Select: begin
                if (cand.solved) begin
                    nextState = Emit;
                end else if (cand.contradiction) begin
                    // contradiction with nothing to undo means no solution
                    nextState = (depth == '0) ? Idle : Clear;
                end else begin
                    nextState = Try;
                end
            end
            Try:   nextState = Select;
            Clear: nextState = Retry;
            Retry: begin
                if (remaining != '0) begin
                    nextState = Try;
                end else if (depth > stackDepth'(1)) begin
                    nextState = Clear;
                end else begin
                    nextState = Idle;
                end
            end
            Emit: begin
                if (emitCnt == cellIndex'(`CELL_COUNT - 1)) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // ==================================================
    // board controls
    // ==================================================

    always_comb begin
        loadEn    = inValid && (state == Idle || state == Load);
        updateEn  = 1'b0;
        updateIdx = topIdx;
        updateVal = '0;
        case (state)
            Try: begin
                updateEn  = 1'b1;
                updateVal = maskToDigit(pickBit);
            end
            // undo the top placement
            Clear: updateEn = 1'b1;
            default: updateEn = 1'b0;
        endcase
    end

    assign emitEn  = (state == Emit);
    assign readIdx = emitCnt;

    // ==================================================
    // state, depth and emit counter
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= Idle;
            depth   <= '0;
            emitCnt <= '0;
        end else begin
            state <= nextState;
            if (state == Idle) begin
                depth <= '0;
            end else if (pushEn) begin
                depth <= depth + 1'b1;
            end else if (state == Retry && remaining == '0) begin
                // pop since this cell has run out of digits
                depth <= depth - 1'b1;
            end
            if (state == Emit && nextState == Emit) begin
                emitCnt <= emitCnt + 1'b1;
            end else begin
                emitCnt <= '0;
            end
        end
    end

    // stack payload
    always_ff @(posedge clk) begin
        if (pushEn) begin
            stackIdx[depth]   <= cand.bestIdx;
            stackTried[depth] <= '0;
        end else if (state == Try) begin
            stackTried[depth - 1'b1] <= topTried | pickBit;
        end
    end

    // one entry per board cell at most
    assert property (@(posedge clk) disable iff (!rst_n) depth <= `CELL_COUNT);

    // evaluator must still offer a digit whenever a branch is tried
    assert property (@(posedge clk) disable iff (!rst_n) state == Try |-> remaining != '0);

endmodule

`default_nettype wire

// File: src/sudokuSolver.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module sudokuSolver import sudokuPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic [3:0] in,
    output logic       out_valid,
    output logic [3:0] out
);

    // ==================================================
    // internal wiring
    // ==================================================

    candidateIf candBus ();

    cellValue boardCells [`CELL_COUNT];
    digitMask candMasks  [`CELL_COUNT];

    logic     loadEn;
    logic     updateEn;
    logic     emitEn;
    cellIndex updateIdx;
    cellIndex readIdx;
    cellValue updateVal;

    // board store that also drives the serial output
    sudokuBoard board_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .loadEn       (loadEn),
        .loadVal      (in),
        .updateEn     (updateEn),
        .updateIdx    (updateIdx),
        .updateVal    (updateVal),
        .readIdx      (readIdx),
        .emitEn       (emitEn),
        .cells        (boardCells),
        .cellOut      (out),
        .cellOutValid (out_valid)
    );

    // constraint masks and status
    constraintEval eval_i (
        .cells      (boardCells),
        .candidates (candMasks),
        .cand       (candBus.evalPort)
    );

    // MRV pick
    cellSelector select_i (
        .candidates (candMasks),
        .cand       (candBus.selectPort)
    );

    searchControl search_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inValid   (in_valid),
        .cand      (candBus.searchPort),
        .loadEn    (loadEn),
        .updateEn  (updateEn),
        .updateIdx (updateIdx),
        .updateVal (updateVal),
        .readIdx   (readIdx),
        .emitEn    (emitEn)
    );

endmodule

`default_nettype wire

// File: test/sudokuSolverTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sudoku_params.svh"

module sudokuSolverTb import sudokuPkg::*; ();

    // bounds for every wait
    localparam int solveTimeout = 400000;
    localparam int quietCycles  = 3000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [3:0] in;
    logic       out_valid;
    logic [3:0] out;

    cellValue    puzzle    [`CELL_COUNT];
    cellValue    reference [`CELL_COUNT];
    cellValue    result    [`CELL_COUNT];
    logic [31:0] lfsrState;

    // hard puzzle needing deep backtracking and its unique solution
    string hardText = {"800000000", "003600000", "070090200", "050007000", "000045700",
                       "000100030", "001000068", "008500010", "090000400"};
    string solText  = {"812753649", "943682175", "675491283", "154237896", "369845721",
                       "287169534", "521974368", "438526917", "796318452"};
    // corner cell sees 1..8 in its row and 9 in its column
    string deadText = {"012345678", "000000000", "000000000", "900000000", "000000000",
                       "000000000", "000000000", "000000000", "000000000"};

    sudokuSolver sudokuSolver_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // helpers
    // ==================================================

    // taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic takeBit(output logic b);
        lfsrState = nextLfsr(lfsrState);
        b = lfsrState[0];
    endtask

    function automatic cellValue digitAt(input string s, input int i);
        return cellValue'(s[i] - 8'd48);
    endfunction

    // position of the k-th cell of row / column / box g
    function automatic int groupCell(input int kind, input int g, input int k);
        if (kind == 0) begin
            return g * `BOARD_SIDE + k;
        end else if (kind == 1) begin
            return k * `BOARD_SIDE + g;
        end
        return (g / `BOX_SIDE) * `BOARD_SIDE * `BOX_SIDE + (g % `BOX_SIDE) * `BOX_SIDE
             + (k / `BOX_SIDE) * `BOARD_SIDE + k % `BOX_SIDE;
    endfunction

    // sample and drive point 1 ns past the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic checkCell(input string name, input cellValue got, input cellValue exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            failRun("cell value differs from the expected value");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            failRun("flag differs from the expected value");
        end
    endtask

    // ==================================================
    // stimulus and collection
    // ==================================================

    task automatic loadPuzzle();
        for (int i = 0; i < `CELL_COUNT; i++) begin
            in_valid = 1'b1;
            in       = puzzle[i];
            stepCycle();
        end
        in_valid = 1'b0;
        in       = '0;
    endtask

    // wait for the first strobe then take 81 back to back
    task automatic collectOutputs();
        int waited;
        waited = 0;
        stepCycle();
        while (!out_valid) begin
            checkCell("out", out, 4'd0);
            if (waited >= solveTimeout) begin
                failRun("timeout while waiting for out_valid");
            end
            waited++;
            stepCycle();
        end
        result[0] = out;
        for (int i = 1; i < `CELL_COUNT; i++) begin
            stepCycle();
            checkFlag("out_valid", out_valid, 1'b1);
            result[i] = out;
        end
        // burst is exactly 81 long and out returns to zero
        stepCycle();
        checkFlag("out_valid", out_valid, 1'b0);
        checkCell("out", out, 4'd0);
    endtask

    task automatic expectSilence(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            stepCycle();
            checkFlag("out_valid", out_valid, 1'b0);
            checkCell("out", out, 4'd0);
        end
    endtask

    // every row, column and box holds 1..9 once
    task automatic checkValidGrid();
        digitMask seen;
        int       idx;
        for (int kind = 0; kind < 3; kind++) begin
            for (int g = 0; g < `BOARD_SIDE; g++) begin
                seen = '0;
                for (int k = 0; k < `BOARD_SIDE; k++) begin
                    idx = groupCell(kind, g, k);
                    if (result[idx] == 4'd0 || result[idx] > 4'd9) begin
                        failRun($sformatf("output cell %0d holds no digit", idx));
                    end else if (seen[result[idx] - 1]) begin
                        failRun($sformatf("digit repeated in group %0d of kind %0d", g, kind));
                    end
                    seen[result[idx] - 1] = 1'b1;
                end
            end
        end
    endtask

    task automatic checkGivensKept();
        for (int i = 0; i < `CELL_COUNT; i++) begin
            if (puzzle[i] != 4'd0) begin
                checkCell($sformatf("out[%0d]", i), result[i], puzzle[i]);
            end
        end
    endtask

    task automatic checkExact();
        for (int i = 0; i < `CELL_COUNT; i++) begin
            checkCell($sformatf("out[%0d]", i), result[i], reference[i]);
        end
    endtask

    // relabeled digits of the known solution still form a valid grid
    task automatic makeShiftedSolution(input int shift);
        for (int i = 0; i < `CELL_COUNT; i++) begin
            reference[i] = cellValue'((digitAt(solText, i) - 1 + shift) % 9 + 1);
        end
    endtask

    // roughly half the cells emptied
    task automatic blankCells();
        logic b;
        for (int i = 0; i < `CELL_COUNT; i++) begin
            takeBit(b);
            puzzle[i] = b ? 4'd0 : reference[i];
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================

    task automatic testResetIdle();
        expectSilence(6);
    endtask

    task automatic testCompleteGrid();
        makeShiftedSolution(3);
        puzzle = reference;
        loadPuzzle();
        collectOutputs();
        checkExact();
    endtask

    task automatic testRandomBlanks(input int shift);
        makeShiftedSolution(shift);
        blankCells();
        loadPuzzle();
        collectOutputs();
        checkValidGrid();
        checkGivensKept();
    endtask

    task automatic testHardPuzzle();
        for (int i = 0; i < `CELL_COUNT; i++) begin
            puzzle[i]    = digitAt(hardText, i);
            reference[i] = digitAt(solText, i);
        end
        loadPuzzle();
        collectOutputs();
        checkExact();
    endtask

    task automatic testUnsolvable();
        for (int i = 0; i < `CELL_COUNT; i++) begin
            puzzle[i] = digitAt(deadText, i);
        end
        loadPuzzle();
        expectSilence(quietCycles);
        // solver must be usable again
        testRandomBlanks(5);
    endtask

    task automatic testBackToBack();
        testRandomBlanks(7);
        stepCycle();
        testHardPuzzle();
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in        = '0;
        lfsrState = 32'hfd617d91;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        testResetIdle();
        testCompleteGrid();
        testRandomBlanks(0);
        testHardPuzzle();
        testUnsolvable();
        testBackToBack();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/sudokuPkg.sv
src/candidateIf.sv
src/sudokuBoard.sv
src/constraintEval.sv
src/cellSelector.sv
src/searchControl.sv
src/sudokuSolver.sv
test/sudokuSolverTb.sv
